//--- logic/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Index bits per cache, 16 lines by default.
`define CACHE_INDEX_BITS 4

// Shared memory size in 32-bit words.
`define MEM_DEPTH_WORDS 1024

// Cycles from accepted request to ready.
`define MEM_LATENCY 3

`endif

//--- logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// One bus word, used for both data and byte addresses.
	typedef logic [31:0] word_t;

	// Arbiter master select.
	typedef enum logic {
		PORT0 = 1'b0,
		PORT1 = 1'b1
	} bus_port_t;

endpackage

`default_nettype wire

//--- logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// Stored cache entry, 64 bits.
	// Field order keeps valid in bit 0 and dirty in bit 1.
	typedef struct packed {
		bus_pkg::word_t data;
		logic [29:0] address;
		logic dirty;
		logic valid;
	} cache_line_t;

	// Controller states.
	typedef enum logic [3:0] {
		ST_INITIALIZE,
		ST_IDLE,
		ST_FLUSH_SETUP,
		ST_FLUSH_CHECK,
		ST_FLUSH_WRITE,
		ST_PASS_THROUGH,
		ST_WRITE_SETUP,
		ST_WB_WAIT,
		ST_READ_SETUP,
		ST_READ_WB_WAIT,
		ST_READ_BUS_WAIT
	} cache_state_t;

endpackage

`default_nettype wire

//--- logic/mem_bus_if.sv
`default_nettype none
`timescale 1ns/100ps

interface mem_bus_if
	import bus_pkg::*;
();

	logic request;
	logic rw;
	word_t address;
	word_t wdata;
	word_t rdata;
	logic ready;

	// Request side, holds request until ready pulses.
	modport master (
		output request, rw, address, wdata,
		input rdata, ready
	);

	// Responding side.
	modport slave (
		input request, rw, address, wdata,
		output rdata, ready
	);

endinterface

`default_nettype wire

//--- logic/sync_ram.sv
`default_nettype none
`timescale 1ns/100ps

module sync_ram #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 16
)(
	input wire i_clock,
	input wire i_write,
	input wire logic [$clog2(DEPTH)-1:0] i_address,
	input wire payload_t i_wdata,
	output payload_t o_rdata
);

	payload_t mem [DEPTH];

	// Registered read, old data on a same-cycle write.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_address] <= i_wdata;
		end
		o_rdata <= mem[i_address];
	end

endmodule

`default_nettype wire

//--- logic/dcache.sv
`default_nettype none
`timescale 1ns/100ps
`include "cache_params.svh"

module dcache
	import bus_pkg::*, cache_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire i_rw,
	input wire i_flush,
	input wire i_cacheable,
	input wire word_t i_address,
	input wire word_t i_wdata,
	output logic o_ready,
	output word_t o_rdata,
	mem_bus_if.master bus
);

	localparam int INDEX_BITS = `CACHE_INDEX_BITS;
	localparam int LINES = 1 << INDEX_BITS;

	cache_state_t state;
	logic [INDEX_BITS:0] sweep_index;

	logic ram_write;
	logic [INDEX_BITS-1:0] ram_index;
	cache_line_t ram_wdata;
	cache_line_t entry;

	logic [29:0] req_word;
	logic [INDEX_BITS-1:0] req_index;
	logic sweeping;
	logic entry_hit;
	logic entry_evict;

	sync_ram #(
		.payload_t(cache_line_t),
		.DEPTH(LINES)
	) u_lines (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_address(ram_index),
		.i_wdata(ram_wdata),
		.o_rdata(entry)
	);

	assign req_word = i_address[31:2];
	assign req_index = i_address[2 +: INDEX_BITS];
	assign sweeping = state inside {ST_INITIALIZE, ST_FLUSH_SETUP, ST_FLUSH_CHECK, ST_FLUSH_WRITE};

	// Sweeps walk the index counter, everything else follows the CPU address.
	assign ram_index = sweeping ? sweep_index[INDEX_BITS-1:0] : req_index;

	assign entry_hit = entry.valid && (entry.address == req_word);
	assign entry_evict = entry.valid && entry.dirty && (entry.address != req_word);

	// Line updates.
	always_comb begin
		ram_write = 1'b0;
		ram_wdata.data = i_wdata;
		ram_wdata.address = req_word;
		ram_wdata.dirty = 1'b1;
		ram_wdata.valid = 1'b1;
		case (state)
			ST_INITIALIZE: begin
				ram_write = !sweep_index[INDEX_BITS];
				ram_wdata = '0;
			end
			ST_FLUSH_WRITE: begin
				ram_write = bus.ready;
				ram_wdata = entry;
				ram_wdata.dirty = 1'b0;
			end
			ST_WRITE_SETUP: ram_write = !entry_evict;
			ST_WB_WAIT: ram_write = bus.ready;
			ST_READ_BUS_WAIT: begin
				// Refill, clean.
				ram_write = bus.request && bus.ready;
				ram_wdata.data = bus.rdata;
				ram_wdata.dirty = 1'b0;
			end
			default: ram_write = 1'b0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		o_ready <= 1'b0;
		if (i_reset) begin
			state <= ST_INITIALIZE;
			sweep_index <= '0;
			bus.request <= 1'b0;
		end
		else begin
			case (state)
				ST_IDLE: begin
					// A request still high during its own ready is old.
					if (i_request && !o_ready) begin
						if (i_flush) begin
							sweep_index <= '0;
							state <= ST_FLUSH_SETUP;
						end
						else if (!i_cacheable) begin
							bus.request <= 1'b1;
							bus.rw <= i_rw;
							bus.address <= i_address;
							bus.wdata <= i_wdata;
							state <= ST_PASS_THROUGH;
						end
						else if (i_rw) begin
							state <= ST_WRITE_SETUP;
						end
						else begin
							state <= ST_READ_SETUP;
						end
					end
				end

				// ==================================================
				// Flush
				// ==================================================
				ST_FLUSH_SETUP: begin
					if (sweep_index[INDEX_BITS]) begin
						o_ready <= 1'b1;
						state <= ST_IDLE;
					end
					else begin
						state <= ST_FLUSH_CHECK;
					end
				end
				ST_FLUSH_CHECK: begin
					if (entry.valid && entry.dirty) begin
						bus.request <= 1'b1;
						bus.rw <= 1'b1;
						bus.address <= {entry.address, 2'b00};
						bus.wdata <= entry.data;
						state <= ST_FLUSH_WRITE;
					end
					else begin
						sweep_index <= sweep_index + 1'b1;
						state <= ST_FLUSH_SETUP;
					end
				end
				ST_FLUSH_WRITE: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						sweep_index <= sweep_index + 1'b1;
						state <= ST_FLUSH_SETUP;
					end
				end

				ST_PASS_THROUGH: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						o_rdata <= bus.rdata;
						o_ready <= 1'b1;
						state <= ST_IDLE;
					end
				end

				// ==================================================
				// Write, allocating
				// ==================================================
				ST_WRITE_SETUP: begin
					if (entry_evict) begin
						bus.request <= 1'b1;
						bus.rw <= 1'b1;
						bus.address <= {entry.address, 2'b00};
						bus.wdata <= entry.data;
						state <= ST_WB_WAIT;
					end
					else begin
						o_ready <= 1'b1;
						state <= ST_IDLE;
					end
				end
				ST_WB_WAIT: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						o_ready <= 1'b1;
						state <= ST_IDLE;
					end
				end

				// ==================================================
				// Read
				// ==================================================
				ST_READ_SETUP: begin
					if (entry_hit) begin
						o_rdata <= entry.data;
						o_ready <= 1'b1;
						state <= ST_IDLE;
					end
					else if (entry_evict) begin
						bus.request <= 1'b1;
						bus.rw <= 1'b1;
						bus.address <= {entry.address, 2'b00};
						bus.wdata <= entry.data;
						state <= ST_READ_WB_WAIT;
					end
					else begin
						bus.request <= 1'b1;
						bus.rw <= 1'b0;
						bus.address <= i_address;
						state <= ST_READ_BUS_WAIT;
					end
				end
				ST_READ_WB_WAIT: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						state <= ST_READ_BUS_WAIT;
					end
				end
				ST_READ_BUS_WAIT: begin
					// Request is low for one cycle after a write-back.
					if (!bus.request) begin
						bus.request <= 1'b1;
						bus.rw <= 1'b0;
						bus.address <= i_address;
					end
					else if (bus.ready) begin
						bus.request <= 1'b0;
						o_rdata <= bus.rdata;
						o_ready <= 1'b1;
						state <= ST_IDLE;
					end
				end

				// Invalidate every line, then one extra cycle.
				ST_INITIALIZE: begin
					if (!sweep_index[INDEX_BITS]) begin
						sweep_index <= sweep_index + 1'b1;
					end
					else begin
						state <= ST_IDLE;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/bus_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module bus_arbiter
	import bus_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	mem_bus_if.slave port0,
	mem_bus_if.slave port1,
	mem_bus_if.master mem
);

	bus_port_t grant;
	bus_port_t next_grant;
	logic busy;
	logic sel0;

	// On contention the port that did not own the last grant wins.
	always_comb begin
		if (port0.request && port1.request) begin
			next_grant = (grant == PORT0) ? PORT1 : PORT0;
		end
		else if (port1.request) begin
			next_grant = PORT1;
		end
		else begin
			next_grant = PORT0;
		end
	end

	// Grant held until memory ready.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			grant <= PORT1;
		end
		else if (!busy) begin
			if (port0.request || port1.request) begin
				busy <= 1'b1;
				grant <= next_grant;
			end
		end
		else if (mem.ready) begin
			busy <= 1'b0;
		end
	end

	assign sel0 = (grant == PORT0);

	// Memory side follows the granted port.
	assign mem.request = busy && (sel0 ? port0.request : port1.request);
	assign mem.rw = sel0 ? port0.rw : port1.rw;
	assign mem.address = sel0 ? port0.address : port1.address;
	assign mem.wdata = sel0 ? port0.wdata : port1.wdata;

	// Response only to the owner.
	assign port0.ready = busy && sel0 && mem.ready;
	assign port1.ready = busy && !sel0 && mem.ready;
	assign port0.rdata = sel0 ? mem.rdata : '0;
	assign port1.rdata = sel0 ? '0 : mem.rdata;

endmodule

`default_nettype wire

//--- logic/main_memory.sv
`default_nettype none
`timescale 1ns/100ps
`include "cache_params.svh"

module main_memory
	import bus_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	mem_bus_if.slave bus
);

	localparam int ADDR_BITS = $clog2(`MEM_DEPTH_WORDS);
	localparam int COUNT_BITS = $clog2(`MEM_LATENCY + 1);

	logic [COUNT_BITS-1:0] wait_count;
	logic ram_write;
	word_t ram_rdata;

	sync_ram #(
		.payload_t(word_t),
		.DEPTH(`MEM_DEPTH_WORDS)
	) u_words (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_address(bus.address[2 +: ADDR_BITS]),
		.i_wdata(bus.wdata),
		.o_rdata(ram_rdata)
	);

	// Write lands at the end of the ready cycle.
	assign ram_write = bus.request && bus.ready && bus.rw;
	assign bus.rdata = ram_rdata;

	always_ff @(posedge i_clock) begin
		bus.ready <= 1'b0;
		if (i_reset) begin
			wait_count <= '0;
		end
		else if (bus.request && !bus.ready) begin
			if (wait_count == COUNT_BITS'(`MEM_LATENCY - 1)) begin
				wait_count <= '0;
				bus.ready <= 1'b1;
			end
			else begin
				wait_count <= wait_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/cache_subsystem_top.sv
`default_nettype none
`timescale 1ns/100ps

module cache_subsystem_top
	import bus_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// CPU port 0.
	input wire i_cpu0_request,
	input wire i_cpu0_rw,
	input wire i_cpu0_flush,
	input wire i_cpu0_cacheable,
	input wire word_t i_cpu0_address,
	input wire word_t i_cpu0_wdata,
	output logic o_cpu0_ready,
	output word_t o_cpu0_rdata,

	// CPU port 1.
	input wire i_cpu1_request,
	input wire i_cpu1_rw,
	input wire i_cpu1_flush,
	input wire i_cpu1_cacheable,
	input wire word_t i_cpu1_address,
	input wire word_t i_cpu1_wdata,
	output logic o_cpu1_ready,
	output word_t o_cpu1_rdata
);

	mem_bus_if cache0_bus ();
	mem_bus_if cache1_bus ();
	mem_bus_if mem_bus ();

	dcache u_cache0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_cpu0_request),
		.i_rw(i_cpu0_rw),
		.i_flush(i_cpu0_flush),
		.i_cacheable(i_cpu0_cacheable),
		.i_address(i_cpu0_address),
		.i_wdata(i_cpu0_wdata),
		.o_ready(o_cpu0_ready),
		.o_rdata(o_cpu0_rdata),
		.bus(cache0_bus)
	);

	dcache u_cache1 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_cpu1_request),
		.i_rw(i_cpu1_rw),
		.i_flush(i_cpu1_flush),
		.i_cacheable(i_cpu1_cacheable),
		.i_address(i_cpu1_address),
		.i_wdata(i_cpu1_wdata),
		.o_ready(o_cpu1_ready),
		.o_rdata(o_cpu1_rdata),
		.bus(cache1_bus)
	);

	bus_arbiter u_arbiter (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.port0(cache0_bus),
		.port1(cache1_bus),
		.mem(mem_bus)
	);

	main_memory u_memory (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.bus(mem_bus)
	);

endmodule

`default_nettype wire

//--- verif/cache_checker.sv
`default_nettype none
`timescale 1ns/100ps

module cache_checker (
	input wire i_clock,
	input wire i_reset,
	input wire i_request0,
	input wire i_ready0,
	input wire i_request1,
	input wire i_ready1,
	input wire i_mem_request,
	input wire i_mem_ready
);

	// Read by the testbench after each cycle.
	int unsigned error_count = 0;

	property held_until_ready(req, rdy);
		@(posedge i_clock) disable iff (i_reset) req && !rdy |=> req;
	endproperty

	property single_cycle_ready(rdy);
		@(posedge i_clock) disable iff (i_reset) rdy |=> !rdy;
	endproperty

	a_held0: assert property (held_until_ready(i_request0, i_ready0))
		else begin
			$error("port 0 dropped request before ready");
			error_count++;
		end
	a_held1: assert property (held_until_ready(i_request1, i_ready1))
		else begin
			$error("port 1 dropped request before ready");
			error_count++;
		end
	a_held_mem: assert property (held_until_ready(i_mem_request, i_mem_ready))
		else begin
			$error("memory request dropped before ready");
			error_count++;
		end
	a_pulse_mem: assert property (single_cycle_ready(i_mem_ready))
		else begin
			$error("memory ready longer than one cycle");
			error_count++;
		end

	// Each memory ready reaches exactly one requesting port.
	a_one_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		i_mem_ready |-> ((i_ready0 && i_request0) != (i_ready1 && i_request1)))
		else begin
			$error("memory ready not returned to exactly one requesting port");
			error_count++;
		end

	// Memory request follows a port request by one cycle.
	a_mem_source: assert property (@(posedge i_clock) disable iff (i_reset)
		i_mem_request |-> (i_request0 || i_request1) && $past(i_request0 || i_request1))
		else begin
			$error("memory request with no port requesting");
			error_count++;
		end

endmodule

bind cache_subsystem_top cache_checker u_checker (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_request0(cache0_bus.request),
	.i_ready0(cache0_bus.ready),
	.i_request1(cache1_bus.request),
	.i_ready1(cache1_bus.ready),
	.i_mem_request(mem_bus.request),
	.i_mem_ready(mem_bus.ready)
);

`default_nettype wire

//--- verif/tb_cache_subsystem.sv
`default_nettype none
`timescale 1ns/100ps
`include "cache_params.svh"

module tb_cache_subsystem
	import bus_pkg::*;
();

	localparam int INDEX_BITS = `CACHE_INDEX_BITS;
	localparam int LINES = 1 << INDEX_BITS;
	localparam int MEM_BITS = $clog2(`MEM_DEPTH_WORDS);
	localparam int POOL_WORDS = 32;
	localparam int RANDOM_OPS = 60;
	localparam int DIRECTED_OPS = 24;

	// Worst request: two bus transactions, each queued behind the other port.
	localparam int PER_REQUEST = 4 * (`MEM_LATENCY + 3) + 4;
	localparam int REQUESTS = 2 * (POOL_WORDS + RANDOM_OPS) + DIRECTED_OPS;
	localparam int SWEEPS = LINES * (2 * (`MEM_LATENCY + 3) + 3) + 2 * (LINES + 8);
	localparam int TIMEOUT_CYCLES = REQUESTS * PER_REQUEST + SWEEPS + 100;

	logic i_clock;
	logic i_reset;
	logic cpu_request [2];
	logic cpu_rw [2];
	logic cpu_flush [2];
	logic cpu_cacheable [2];
	word_t cpu_address [2];
	word_t cpu_wdata [2];
	logic cpu_ready [2];
	word_t cpu_rdata [2];

	// Reference model state.
	word_t model_mem [`MEM_DEPTH_WORDS];
	bit line_valid [2][LINES];
	bit line_dirty [2][LINES];
	logic [29:0] line_word [2][LINES];
	word_t line_data [2][LINES];

	word_t expect_value0 [$];
	word_t expect_value1 [$];
	bit expect_read0 [$];
	bit expect_read1 [$];
	word_t rng [2];
	int cycle_count;

	cache_subsystem_top u_dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_cpu0_request(cpu_request[0]),
		.i_cpu0_rw(cpu_rw[0]),
		.i_cpu0_flush(cpu_flush[0]),
		.i_cpu0_cacheable(cpu_cacheable[0]),
		.i_cpu0_address(cpu_address[0]),
		.i_cpu0_wdata(cpu_wdata[0]),
		.o_cpu0_ready(cpu_ready[0]),
		.o_cpu0_rdata(cpu_rdata[0]),
		.i_cpu1_request(cpu_request[1]),
		.i_cpu1_rw(cpu_rw[1]),
		.i_cpu1_flush(cpu_flush[1]),
		.i_cpu1_cacheable(cpu_cacheable[1]),
		.i_cpu1_address(cpu_address[1]),
		.i_cpu1_wdata(cpu_wdata[1]),
		.o_cpu1_ready(cpu_ready[1]),
		.o_cpu1_rdata(cpu_rdata[1])
	);

	initial begin
		i_clock = 1'b0;
		forever #4 i_clock = ~i_clock;
	end

	// ==================================================
	// Helpers
	// ==================================================
	function automatic word_t xorshift(input word_t state);
		word_t s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic word_t byte_addr(input int word);
		return word_t'(word) << 2;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_word(input int port, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch at %0t: port %0d read %h, expected %h",
				$time, port, actual, expected));
		end
	endtask

	task automatic compare_ready(input int port, input logic expected, input logic actual);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch at %0t: port %0d ready %b, expected %b",
				$time, port, actual, expected));
		end
	endtask

	task automatic compare_latency(input int expected, input int actual);
		if (actual != expected) begin
			fail_run($sformatf("mismatch at %0t: hit took %0d cycles, expected %0d",
				$time, actual, expected));
		end
	endtask

	// ==================================================
	// Reference model
	// ==================================================
	function automatic word_t reference_access(input int port, input bit rw, input bit flush,
		input bit cacheable, input word_t addr, input word_t wdata);
		word_t result;
		logic [29:0] word;
		logic [INDEX_BITS-1:0] idx;
		result = '0;
		word = addr[31:2];
		idx = addr[2 +: INDEX_BITS];
		if (flush) begin
			for (int i = 0; i < LINES; i++) begin
				if (line_valid[port][i] && line_dirty[port][i]) begin
					model_mem[line_word[port][i][MEM_BITS-1:0]] = line_data[port][i];
					line_dirty[port][i] = 1'b0;
				end
			end
		end
		else if (!cacheable) begin
			if (rw) model_mem[word[MEM_BITS-1:0]] = wdata;
			else result = model_mem[word[MEM_BITS-1:0]];
		end
		else begin
			// Dirty victim of another address goes back first.
			if (line_valid[port][idx] && line_dirty[port][idx] && line_word[port][idx] != word) begin
				model_mem[line_word[port][idx][MEM_BITS-1:0]] = line_data[port][idx];
				line_dirty[port][idx] = 1'b0;
			end
			if (rw) begin
				line_data[port][idx] = wdata;
				line_dirty[port][idx] = 1'b1;
			end
			else if (!(line_valid[port][idx] && line_word[port][idx] == word)) begin
				line_data[port][idx] = model_mem[word[MEM_BITS-1:0]];
				line_dirty[port][idx] = 1'b0;
			end
			line_valid[port][idx] = 1'b1;
			line_word[port][idx] = word;
			result = line_data[port][idx];
		end
		return result;
	endfunction

	task automatic apply_reset();
		@(negedge i_clock);
		i_reset = 1'b1;
		repeat (3) @(negedge i_clock);
		i_reset = 1'b0;
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < LINES; i++) begin
				line_valid[p][i] = 1'b0;
				line_dirty[p][i] = 1'b0;
			end
		end
	endtask

	// One CPU request, held until ready, then one idle cycle.
	task automatic run_access(input int port, input bit rw, input bit flush, input bit cacheable,
		input word_t addr, input word_t wdata, output int cycles);
		word_t expected;
		@(negedge i_clock);
		expected = reference_access(port, rw, flush, cacheable, addr, wdata);
		if (port == 0) begin
			expect_value0.push_back(expected);
			expect_read0.push_back(!rw && !flush);
		end
		else begin
			expect_value1.push_back(expected);
			expect_read1.push_back(!rw && !flush);
		end
		cpu_rw[port] = rw;
		cpu_flush[port] = flush;
		cpu_cacheable[port] = cacheable;
		cpu_address[port] = addr;
		cpu_wdata[port] = wdata;
		cpu_request[port] = 1'b1;
		cycles = 0;
		do begin
			@(negedge i_clock);
			cycles++;
		end while (!cpu_ready[port]);
		cpu_request[port] = 1'b0;
	endtask

	task automatic random_traffic(input int port, input int base);
		int cycles;
		int word;
		word_t r;
		// Known contents for the whole pool first.
		for (int i = 0; i < POOL_WORDS; i++) begin
			rng[port] = xorshift(rng[port]);
			run_access(port, 1'b1, 1'b0, 1'b0, byte_addr(base + i), rng[port], cycles);
		end
		for (int i = 0; i < RANDOM_OPS; i++) begin
			rng[port] = xorshift(rng[port]);
			r = rng[port];
			word = base + int'(r[4:0]);
			rng[port] = xorshift(rng[port]);
			run_access(port, r[8], 1'b0, !r[9], byte_addr(word), rng[port], cycles);
		end
	endtask

	// ==================================================
	// Compare and timeout
	// ==================================================
	task automatic check_port(input int port);
		word_t expected;
		bit is_read;
		if (cpu_ready[port]) begin
			if (port == 0) begin
				compare_ready(port, expect_value0.size() > 0, 1'b1);
				expected = expect_value0.pop_front();
				is_read = expect_read0.pop_front();
			end
			else begin
				compare_ready(port, expect_value1.size() > 0, 1'b1);
				expected = expect_value1.pop_front();
				is_read = expect_read1.pop_front();
			end
			if (is_read) compare_word(port, expected, cpu_rdata[port]);
		end
	endtask

	initial begin
		forever begin
			@(negedge i_clock);
			if (!i_reset) begin
				check_port(0);
				check_port(1);
			end
			if (u_dut.u_checker.error_count != 0) fail_run("bus protocol assertion failed");
		end
	end

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge i_clock);
			cycle_count++;
			if (cycle_count >= TIMEOUT_CYCLES) fail_run("timeout: a port never answered");
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		int cycles;
		i_reset = 1'b1;
		for (int p = 0; p < 2; p++) begin
			cpu_request[p] = 1'b0;
			cpu_rw[p] = 1'b0;
			cpu_flush[p] = 1'b0;
			cpu_cacheable[p] = 1'b0;
			cpu_address[p] = '0;
			cpu_wdata[p] = '0;
		end
		rng[0] = 32'h73b8;
		rng[1] = xorshift(32'h73b8);
		apply_reset();

		// Uncached round trip.
		run_access(0, 1'b1, 1'b0, 1'b0, byte_addr(10), 32'hcafe_0010, cycles);
		run_access(0, 1'b0, 1'b0, 1'b0, byte_addr(10), '0, cycles);

		// Cached write, then a read hit.
		run_access(0, 1'b1, 1'b0, 1'b1, byte_addr(20), 32'h1234_0020, cycles);
		run_access(0, 1'b0, 1'b0, 1'b1, byte_addr(20), '0, cycles);
		compare_latency(2, cycles);

		// Words 33 and 49 share index 1.
		run_access(0, 1'b1, 1'b0, 1'b1, byte_addr(33), 32'haaaa_0033, cycles);
		run_access(0, 1'b1, 1'b0, 1'b1, byte_addr(49), 32'hbbbb_0049, cycles);
		run_access(0, 1'b0, 1'b0, 1'b1, byte_addr(33), '0, cycles);

		// Flush, then check memory directly.
		for (int i = 64; i < 68; i++) begin
			run_access(0, 1'b1, 1'b0, 1'b1, byte_addr(i), 32'h5500_0000 + i, cycles);
		end
		run_access(0, 1'b0, 1'b1, 1'b1, '0, '0, cycles);
		for (int i = 64; i < 68; i++) begin
			run_access(0, 1'b0, 1'b0, 1'b0, byte_addr(i), '0, cycles);
		end

		fork
			random_traffic(0, 256);
			random_traffic(1, 768);
		join

		// Dirty data lost on reset, memory value returns.
		run_access(0, 1'b1, 1'b0, 1'b0, byte_addr(100), 32'h0000_0100, cycles);
		run_access(0, 1'b1, 1'b0, 1'b1, byte_addr(100), 32'hdead_0100, cycles);
		apply_reset();
		run_access(0, 1'b0, 1'b0, 1'b1, byte_addr(100), '0, cycles);
		run_access(1, 1'b0, 1'b0, 1'b1, byte_addr(768), '0, cycles);

		@(negedge i_clock);
		if (u_dut.u_checker.error_count != 0) begin
			fail_run("bus protocol assertion failed");
		end
		else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+logic
logic/bus_pkg.sv
logic/cache_pkg.sv
logic/mem_bus_if.sv
logic/sync_ram.sv
logic/dcache.sv
logic/bus_arbiter.sv
logic/main_memory.sv
logic/cache_subsystem_top.sv
verif/cache_checker.sv
verif/tb_cache_subsystem.sv

//--- Makefile
# Verilator build and run of the cache subsystem testbench.

TOP       ?= tb_cache_subsystem
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
